/* design/exec_pkg.sv */
// execute stage package.
// widths, word and code types, operation codes and the request and response structs.
package exec_pkg;

  localparam int word_w     = 16;
  localparam int nibble_w   = 4;
  localparam int num_slices = 4;

  typedef logic [word_w-1:0]   word_t;
  typedef logic [nibble_w-1:0] nibble_t;
  typedef logic [2:0]          alu_op_t;
  typedef logic [2:0]          res_sel_t;
  typedef logic [1:0]          set_cond_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // alu operations, shifts in the low half.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam alu_op_t op_rol = 3'd0;
  localparam alu_op_t op_sll = 3'd1;
  localparam alu_op_t op_ror = 3'd2;
  localparam alu_op_t op_srl = 3'd3;
  localparam alu_op_t op_add = 3'd4;
  localparam alu_op_t op_and = 3'd5;
  localparam alu_op_t op_or  = 3'd6;
  localparam alu_op_t op_xor = 3'd7;

  localparam res_sel_t res_alu    = 3'd0;
  localparam res_sel_t res_pass_a = 3'd1;
  localparam res_sel_t res_pass_b = 3'd2;
  localparam res_sel_t res_set    = 3'd3;
  localparam res_sel_t res_btr    = 3'd4;
  localparam res_sel_t res_slbi   = 3'd5;

  localparam set_cond_t cond_eq = 2'd0;
  localparam set_cond_t cond_lt = 2'd1;
  localparam set_cond_t cond_le = 2'd2;
  localparam set_cond_t cond_co = 2'd3;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stage interface structs.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef struct packed {
    alu_op_t   alu_op;
    logic      src_imm;
    logic      inv_a;
    logic      inv_b;
    logic      cin;
    logic      sign;
    res_sel_t  res_sel;
    set_cond_t set_cond;
    logic      jump_reg;
  } exec_ctrl_t;

  typedef struct packed {
    exec_ctrl_t ctrl;
    word_t      rs_a;
    word_t      rs_b;
    word_t      imm;
    word_t      pc;
    word_t      jump_off;
  } exec_req_t;

  typedef struct packed {
    word_t result;
    word_t branch_target;
    word_t jump_target;
    logic  zero;
    logic  ltz;
    logic  err;
  } exec_rsp_t;

  // slice 0 holds the low nibble.
  typedef struct packed {
    nibble_t [num_slices-1:0] a;
    nibble_t [num_slices-1:0] b;
  } slice_ops_t;

endpackage

/* design/operand_select.sv */
// operand select for the execute stage.
// picks operand b, applies the inversions and splits both words into slice nibbles.
`timescale 1ns/1ns

module operand_select (
  input  exec_pkg::exec_ctrl_t ctrl,
  input  exec_pkg::word_t      rs_a,
  input  exec_pkg::word_t      rs_b,
  input  exec_pkg::word_t      imm,
  output exec_pkg::word_t      op_b,
  output exec_pkg::word_t      op_a_full,
  output exec_pkg::word_t      op_b_full,
  output exec_pkg::slice_ops_t slice_ops
);

  import exec_pkg::*;

  // raw operand b, also used for shift amounts and pass_b.
  always_comb begin
    if (ctrl.src_imm) begin
      op_b = imm;
    end else begin
      op_b = rs_b;
    end
  end

  // inverted operands let the adder do subtraction with cin.
  always_comb begin
    if (ctrl.inv_a) begin
      op_a_full = ~rs_a;
    end else begin
      op_a_full = rs_a;
    end
  end

  always_comb begin
    if (ctrl.inv_b) begin
      op_b_full = ~op_b;
    end else begin
      op_b_full = op_b;
    end
  end

  // one nibble of each operand per slice.
  always_comb begin
    for (int i = 0; i < num_slices; i++) begin
      slice_ops.a[i] = op_a_full[i*nibble_w +: nibble_w];
      slice_ops.b[i] = op_b_full[i*nibble_w +: nibble_w];
    end
  end

endmodule

/* design/alu_slice.sv */
// 4-bit alu slice.
// ripple-carry add or bitwise logic, with carry out and signed overflow.
`timescale 1ns/1ns

module alu_slice (
  input  exec_pkg::alu_op_t alu_op,
  input  exec_pkg::nibble_t a,
  input  exec_pkg::nibble_t b,
  input  logic              carry_in,
  output exec_pkg::nibble_t sum,
  output logic              carry_out,
  output logic              ovf
);

  import exec_pkg::*;

  logic [nibble_w:0] carry;
  nibble_t           add_sum;

  // bit-serial ripple chain.
  always_comb begin
    carry[0] = carry_in;
    for (int i = 0; i < nibble_w; i++) begin
      add_sum[i]   = a[i] ^ b[i] ^ carry[i];
      carry[i+1]   = (a[i] & b[i]) | (carry[i] & (a[i] ^ b[i]));
    end
  end

  always_comb begin
    case (alu_op)
      op_and:  sum = a & b;
      op_or:   sum = a | b;
      op_xor:  sum = a ^ b;
      default: sum = add_sum;
    endcase
  end

  assign carry_out = carry[nibble_w];

  // carry into and out of the top bit disagree on overflow.
  assign ovf = carry[nibble_w] ^ carry[nibble_w-1];

endmodule

/* design/shifter.sv */
// barrel shifter for the execute stage.
// four log stages handle rol, sll and srl. ror reuses the rol path.
`timescale 1ns/1ns

module shifter (
  input  exec_pkg::alu_op_t alu_op,
  input  exec_pkg::word_t   a,
  input  exec_pkg::nibble_t amount,
  output exec_pkg::word_t   shifted
);

  import exec_pkg::*;

  nibble_t stage_amt;
  word_t   stage [0:nibble_w];

  // rotate right by n is rotate left by sixteen minus n.
  always_comb begin
    if (alu_op == op_ror) begin
      stage_amt = -amount;
    end else begin
      stage_amt = amount;
    end
  end

  assign stage[0] = a;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stage g moves by 2**g bits.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  for (genvar g = 0; g < nibble_w; g++) begin : g_stage
    localparam int sh = 1 << g;

    word_t moved;

    always_comb begin
      case (alu_op)
        op_sll:  moved = stage[g] << sh;
        op_srl:  moved = stage[g] >> sh;
        default: moved = (stage[g] << sh) | (stage[g] >> (word_w - sh));
      endcase
    end

    assign stage[g+1] = stage_amt[g] ? moved : stage[g];
  end

  assign shifted = stage[nibble_w];

endmodule

/* design/result_select.sv */
// result select for the execute stage.
// joins the alu word, derives flags and set conditions, then muxes the final result.
`timescale 1ns/1ns

module result_select (
  input  exec_pkg::exec_ctrl_t ctrl,
  input  exec_pkg::word_t      slice_sum,
  input  logic                 carry_out,
  input  logic                 ovf,
  input  exec_pkg::word_t      shifted,
  input  exec_pkg::word_t      rs_a,
  input  exec_pkg::word_t      op_b,
  input  exec_pkg::word_t      imm,
  output exec_pkg::word_t      result,
  output logic                 zero,
  output logic                 ltz,
  output logic                 alu_err
);

  import exec_pkg::*;

  logic  is_shift;
  logic  set_hit;
  word_t alu_word;
  word_t btr_word;
  word_t slbi_word;

  assign is_shift = ctrl.alu_op inside {op_rol, op_sll, op_ror, op_srl};
  assign alu_word = is_shift ? shifted : slice_sum;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // flags and set conditions.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign zero = (alu_word == '0);

  // unsigned compare works off the borrow, i.e. no carry out.
  always_comb begin
    if (ctrl.sign) begin
      ltz = alu_word[word_w-1] ^ ovf;
    end else begin
      ltz = ~carry_out;
    end
  end

  always_comb begin
    case (ctrl.set_cond)
      cond_eq: set_hit = zero;
      cond_lt: set_hit = ltz;
      cond_le: set_hit = zero | ltz;
      cond_co: set_hit = ctrl.sign ? ovf : carry_out;
      default: set_hit = 1'b0;
    endcase
  end

  assign alu_err = ctrl.sign & (ctrl.alu_op == op_add) & ovf;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // special results and final mux.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    for (int i = 0; i < word_w; i++) begin
      btr_word[i] = rs_a[word_w-1-i];
    end
  end

  assign slbi_word = (rs_a << 8) | imm;

  always_comb begin
    case (ctrl.res_sel)
      res_alu:    result = alu_word;
      res_pass_a: result = rs_a;
      res_pass_b: result = op_b;
      res_set:    result = word_t'(set_hit);
      res_btr:    result = btr_word;
      res_slbi:   result = slbi_word;
      default:    result = alu_word;
    endcase
  end

endmodule

/* design/target_calc.sv */
// branch and jump target adders.
// the branch carry feeds the stage error flag.
`timescale 1ns/1ns

module target_calc (
  input  logic            jump_reg,
  input  exec_pkg::word_t pc,
  input  exec_pkg::word_t imm,
  input  exec_pkg::word_t rs_a,
  input  exec_pkg::word_t jump_off,
  output exec_pkg::word_t branch_target,
  output exec_pkg::word_t jump_target,
  output logic            branch_carry
);

  import exec_pkg::*;

  logic [word_w:0] branch_full;
  word_t           jump_base;

  // one extra bit holds the carry out.
  assign branch_full   = {1'b0, pc} + {1'b0, imm};
  assign branch_target = branch_full[word_w-1:0];
  assign branch_carry  = branch_full[word_w];

  // register jumps take rs_a as base.
  always_comb begin
    if (jump_reg) begin
      jump_base = rs_a;
    end else begin
      jump_base = pc;
    end
  end

  assign jump_target = jump_base + jump_off;

endmodule

/* design/execute_stage.sv */
// execute stage top level.
// combinational alu, shifter and target path, registered on the valid strobe.
`timescale 1ns/1ns

module execute_stage (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                in_valid,
  input  exec_pkg::exec_req_t req,
  output logic                out_valid,
  output exec_pkg::exec_rsp_t rsp
);

  import exec_pkg::*;

  word_t                    op_b;
  word_t                    op_a_full;
  slice_ops_t               slice_ops;
  logic [num_slices:0]      carry;
  logic [num_slices-1:0]    slice_ovf;
  nibble_t [num_slices-1:0] slice_sum;
  word_t                    shifted;
  logic                     alu_err;
  logic                     branch_carry;
  logic                     is_pass;
  exec_rsp_t                rsp_next;

  operand_select u_operand_select (
    .ctrl      (req.ctrl),
    .rs_a      (req.rs_a),
    .rs_b      (req.rs_b),
    .imm       (req.imm),
    .op_b      (op_b),
    .op_a_full (op_a_full),
    .op_b_full (),
    .slice_ops (slice_ops)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // slice chain, low nibble first.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign carry[0] = req.ctrl.cin;

  for (genvar g = 0; g < num_slices; g++) begin : g_slice
    alu_slice u_alu_slice (
      .alu_op    (req.ctrl.alu_op),
      .a         (slice_ops.a[g]),
      .b         (slice_ops.b[g]),
      .carry_in  (carry[g]),
      .sum       (slice_sum[g]),
      .carry_out (carry[g+1]),
      .ovf       (slice_ovf[g])
    );
  end

  shifter u_shifter (
    .alu_op  (req.ctrl.alu_op),
    .a       (op_a_full),
    .amount  (op_b[nibble_w-1:0]),
    .shifted (shifted)
  );

  result_select u_result_select (
    .ctrl      (req.ctrl),
    .slice_sum (slice_sum),
    .carry_out (carry[num_slices]),
    .ovf       (slice_ovf[num_slices-1]),
    .shifted   (shifted),
    .rs_a      (req.rs_a),
    .op_b      (op_b),
    .imm       (req.imm),
    .result    (rsp_next.result),
    .zero      (rsp_next.zero),
    .ltz       (rsp_next.ltz),
    .alu_err   (alu_err)
  );

  target_calc u_target_calc (
    .jump_reg      (req.ctrl.jump_reg),
    .pc            (req.pc),
    .imm           (req.imm),
    .rs_a          (req.rs_a),
    .jump_off      (req.jump_off),
    .branch_target (rsp_next.branch_target),
    .jump_target   (rsp_next.jump_target),
    .branch_carry  (branch_carry)
  );

  // pass-through results never flag an error.
  assign is_pass      = (req.ctrl.res_sel == res_pass_a) || (req.ctrl.res_sel == res_pass_b);
  assign rsp_next.err = (alu_err | branch_carry) & ~is_pass;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // output register.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
      rsp       <= '0;
    end else begin
      out_valid <= in_valid;
      if (in_valid) begin
        rsp <= rsp_next;
      end
    end
  end

  a_valid_latency: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid == $past(in_valid));

  a_rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
    !out_valid && $past(rst_n) |-> $stable(rsp));

  a_pass_no_err: assert property (@(posedge clk) disable iff (!rst_n)
    in_valid && is_pass |=> !rsp.err);

endmodule

/* tests/exec_model.svh */
// reference model of the execute stage.
// computes the expected response for one request.
`ifndef exec_model_svh
`define exec_model_svh

function automatic exec_rsp_t expected_response(input exec_req_t r);
  exec_rsp_t   rsp;
  word_t       b_raw;
  word_t       a_op;
  word_t       b_op;
  word_t       word;
  logic [16:0] add_full;
  logic [16:0] br_full;
  logic [31:0] dbl;
  logic [3:0]  n;
  integer      s_sum;
  logic        carry;
  logic        ovf;
  logic        hit;
  logic        is_pass;
  b_raw = r.ctrl.src_imm ? r.imm : r.rs_b;
  a_op = r.ctrl.inv_a ? ~r.rs_a : r.rs_a;
  b_op = r.ctrl.inv_b ? ~b_raw : b_raw;
  add_full = {1'b0, a_op} + {1'b0, b_op} + 17'(r.ctrl.cin);
  carry = add_full[16];
  // signed sum in a wide integer, overflow is leaving the 16-bit range.
  s_sum = {{16{a_op[15]}}, a_op};
  s_sum = s_sum + {{16{b_op[15]}}, b_op};
  s_sum = s_sum + (r.ctrl.cin ? 1 : 0);
  ovf = (s_sum > 32767) || (s_sum < -32768);
  n = b_raw[3:0];
  case (r.ctrl.alu_op)
    op_add: word = add_full[15:0];
    op_and: word = a_op & b_op;
    op_or:  word = a_op | b_op;
    op_xor: word = a_op ^ b_op;
    op_sll: word = a_op << n;
    op_srl: word = a_op >> n;
    op_rol: begin
      dbl = {a_op, a_op} << n;
      word = dbl[31:16];
    end
    default: begin
      dbl = {a_op, a_op} >> n;
      word = dbl[15:0];
    end
  endcase
  rsp.zero = (word == 16'h0000);
  rsp.ltz = r.ctrl.sign ? (word[15] ^ ovf) : !carry;
  case (r.ctrl.set_cond)
    cond_eq: hit = rsp.zero;
    cond_lt: hit = rsp.ltz;
    cond_le: hit = rsp.zero || rsp.ltz;
    default: hit = r.ctrl.sign ? ovf : carry;
  endcase
  case (r.ctrl.res_sel)
    res_pass_a: rsp.result = r.rs_a;
    res_pass_b: rsp.result = b_raw;
    res_set:    rsp.result = {15'd0, hit};
    res_btr:    rsp.result = {<<{r.rs_a}};
    res_slbi:   rsp.result = {r.rs_a[7:0], 8'h00} | r.imm;
    default:    rsp.result = word;
  endcase
  br_full = {1'b0, r.pc} + {1'b0, r.imm};
  rsp.branch_target = br_full[15:0];
  rsp.jump_target = (r.ctrl.jump_reg ? r.rs_a : r.pc) + r.jump_off;
  is_pass = (r.ctrl.res_sel == res_pass_a) || (r.ctrl.res_sel == res_pass_b);
  rsp.err = ((r.ctrl.sign && r.ctrl.alu_op == op_add && ovf) || br_full[16]) && !is_pass;
  return rsp;
endfunction

`endif

/* tests/execute_stage_tb.sv */
// testbench for the execute stage.
// seeded random requests checked against the reference model, one cycle later.
`timescale 1ns/1ns

module execute_stage_tb;

  import exec_pkg::*;

  `include "exec_model.svh"

  localparam int clk_period    = 40;
  localparam int total_reqs    = 200 + 100 + 150 + 120 + 120;
  localparam int margin_cycles = 100;

  logic      clk;
  logic      rst_n;
  logic      in_valid;
  logic      out_valid;
  exec_req_t req;
  exec_rsp_t rsp;
  exec_rsp_t exp_rsp;
  logic      exp_valid;
  integer    seed;
  int        pass_count;
  int        fail_count;

  word_t    edge_vals [0:4]    = '{16'h0000, 16'h0001, 16'h7fff, 16'h8000, 16'hffff};
  alu_op_t  logic_ops [0:3]    = '{op_add, op_and, op_or, op_xor};
  alu_op_t  shift_ops [0:3]    = '{op_rol, op_sll, op_ror, op_srl};
  res_sel_t special_sels [0:3] = '{res_btr, res_slbi, res_pass_a, res_pass_b};

  execute_stage u_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .req       (req),
    .out_valid (out_valid),
    .rsp       (rsp)
  );

  always #(clk_period / 2) clk = ~clk;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // expected slot and checker.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always @(posedge clk) begin
    if (!rst_n) begin
      exp_valid <= 1'b0;
      exp_rsp   <= '0;
    end else begin
      exp_valid <= in_valid;
      if (in_valid) begin
        exp_rsp <= expected_response(req);
      end
    end
  end

  task automatic check_value(input string what, input logic [15:0] got, input logic [15:0] exp);
    if (got !== exp) begin
      fail_count++;
      $display("mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end else begin
      pass_count++;
    end
  endtask

  // outputs settle after the rising edge, so compare on the falling one.
  initial begin
    @(posedge clk);
    forever begin
      @(negedge clk);
      check_value("out_valid", 16'(out_valid), 16'(exp_valid));
      check_value("result", rsp.result, exp_rsp.result);
      check_value("branch_target", rsp.branch_target, exp_rsp.branch_target);
      check_value("jump_target", rsp.jump_target, exp_rsp.jump_target);
      check_value("zero", 16'(rsp.zero), 16'(exp_rsp.zero));
      check_value("ltz", 16'(rsp.ltz), 16'(exp_rsp.ltz));
      check_value("err", 16'(rsp.err), 16'(exp_rsp.err));
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stimulus helpers.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  function automatic word_t rand_word();
    logic [31:0] bits;
    bits = $random(seed);
    return bits[15:0];
  endfunction

  function automatic exec_req_t random_request();
    exec_req_t   r;
    logic [31:0] bits;
    bits = $random(seed);
    r.ctrl.alu_op   = bits[2:0];
    r.ctrl.src_imm  = bits[3];
    r.ctrl.inv_a    = bits[4];
    r.ctrl.inv_b    = bits[5];
    r.ctrl.cin      = bits[6];
    r.ctrl.sign     = bits[7];
    r.ctrl.res_sel  = 3'(bits[15:8] % 8'd6);
    r.ctrl.set_cond = bits[17:16];
    r.ctrl.jump_reg = bits[18];
    r.rs_a     = rand_word();
    r.rs_b     = rand_word();
    r.imm      = rand_word();
    r.pc       = rand_word();
    r.jump_off = rand_word();
    return r;
  endfunction

  task automatic drive(input exec_req_t r, input logic valid);
    @(posedge clk);
    req      <= r;
    in_valid <= valid;
  endtask

  // idle cycles with fresh inputs also check that rsp holds.
  task automatic close_test(input string name, input int fails_before);
    repeat (3) drive(random_request(), 1'b0);
    @(posedge clk);
    $display("test %s done, %0d errors", name, fail_count - fails_before);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // test sequence.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin
    exec_req_t   r;
    logic [31:0] bits;
    clk        = 1'b0;
    rst_n      = 1'b0;
    in_valid   = 1'b0;
    req        = '0;
    seed       = 32'hb1a1_a7e4;
    pass_count = 0;
    fail_count = 0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    close_test("reset", 0);

    for (int i = 0; i < 200; i++) begin
      r = random_request();
      r.ctrl.alu_op  = logic_ops[r.ctrl.alu_op[1:0]];
      r.ctrl.res_sel = res_alu;
      drive(r, 1'b1);
    end
    close_test("alu", fail_count);

    // every amount for each shift code, through either operand b source.
    for (int i = 0; i < 100; i++) begin
      r = random_request();
      r.ctrl.alu_op  = shift_ops[(i / 16) % 4];
      r.ctrl.res_sel = res_alu;
      if (r.ctrl.src_imm) begin
        r.imm[3:0] = 4'(i);
      end else begin
        r.rs_b[3:0] = 4'(i);
      end
      drive(r, 1'b1);
    end
    close_test("shift", fail_count);

    // a minus b, with equal and edge operands mixed in.
    for (int i = 0; i < 150; i++) begin
      r = random_request();
      bits = $random(seed);
      r.ctrl.alu_op  = op_add;
      r.ctrl.res_sel = res_set;
      r.ctrl.src_imm = 1'b0;
      r.ctrl.inv_a   = 1'b0;
      r.ctrl.inv_b   = 1'b1;
      r.ctrl.cin     = 1'b1;
      if (bits[1:0] == 2'd0) begin
        r.rs_b = r.rs_a;
      end else if (bits[1:0] == 2'd1) begin
        r.rs_a = edge_vals[bits[4:2] % 3'd5];
        r.rs_b = edge_vals[bits[7:5] % 3'd5];
      end
      drive(r, 1'b1);
    end
    close_test("set", fail_count);

    // same-signed large operands always overflow.
    for (int i = 0; i < 120; i++) begin
      r = random_request();
      bits = $random(seed);
      r.ctrl.alu_op  = op_add;
      r.ctrl.sign    = 1'b1;
      r.ctrl.src_imm = 1'b0;
      r.ctrl.inv_a   = 1'b0;
      r.ctrl.inv_b   = 1'b0;
      r.ctrl.cin     = 1'b0;
      r.ctrl.res_sel = special_sels[bits[1:0]];
      r.rs_a[15:13]  = bits[2] ? 3'b011 : 3'b100;
      r.rs_b[15:13]  = bits[2] ? 3'b011 : 3'b100;
      drive(r, 1'b1);
    end
    close_test("special", fail_count);

    for (int i = 0; i < 120; i++) begin
      r = random_request();
      bits = $random(seed);
      r.ctrl.jump_reg = i[0];
      drive(r, bits[0] | bits[1]);
    end
    close_test("targets", fail_count);

    $display("checks passed %0d, failed %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  initial begin
    #((total_reqs + margin_cycles) * clk_period);
    $display("timeout: the tests did not finish in the expected time");
    $display("=== FAIL ===");
    $finish;
  end

endmodule

/* verilog.f */
+incdir+tests
design/exec_pkg.sv
design/operand_select.sv
design/alu_slice.sv
design/shifter.sv
design/result_select.sv
design/target_calc.sv
design/execute_stage.sv
tests/execute_stage_tb.sv

/* Bender.yml */
package:
  name: execute_stage

sources:
  - design/exec_pkg.sv
  - design/operand_select.sv
  - design/alu_slice.sv
  - design/shifter.sv
  - design/result_select.sv
  - design/target_calc.sv
  - design/execute_stage.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/execute_stage_tb.sv
